// ==== src/vpu_pkg.sv ====
`default_nettype none

package vpu_pkg;

   localparam int NUM_LANES = 4;
   localparam int VRF_ROWS  = 32;
   localparam int NUM_SEQ   = 2;

   typedef logic [31:0] lane_word_t;
   typedef logic [4:0]  row_addr_t;
   typedef logic [3:0]  row_cnt_t;   // 1 to 8 rows

   typedef enum logic [1:0] {E8 = 2'd0, E16 = 2'd1, E32 = 2'd2} sew_e;

   typedef enum logic [2:0]
   {
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MINU, OP_MAXU, OP_PASS
   } alu_op_e;

   typedef enum logic [1:0] {OP2_VEC = 2'd0, OP2_SCALAR = 2'd1, OP2_IMM = 2'd2} op2_sel_e;

   // Read side, travels to T+1
   typedef struct packed
   {
      alu_op_e    op;
      op2_sel_e   op2_sel;
      sew_e       sew;
      lane_word_t scalar;
      logic [4:0] imm;
      row_addr_t  vd_row;
      logic       store;
   } issue_t;

   // Write side, travels to T+2
   typedef struct packed
   {
      logic      wr_en;
      row_addr_t vd_row;
      logic      store;
   } wb_t;

   // Flat byte index in the ALU slots for byte byt of a lane
   function automatic int slot_idx(sew_e sew, int lane, int byt);
      case (sew)
         E16:     slot_idx = (lane - lane % 2 + byt / 2) * 4 + (byt % 2) * 2 + lane % 2;
         E32:     slot_idx = (lane - lane % 4 + byt) * 4 + lane % 4;
         default: slot_idx = lane * 4 + byt;
      endcase
   endfunction

endpackage

`default_nettype wire

// ==== src/stage_delay.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_delay #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 1
)
(
   input  logic     clk_i,
   input  logic     rst_i,
   input  logic     vld_i,
   input  payload_t data_i,
   output logic     vld_o,
   output payload_t data_o
);
   logic [DEPTH-1:0] vld_q;
   payload_t         data_q [DEPTH];

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         vld_q <= '0;
      else
      begin
         vld_q[0] <= vld_i;
         for (int i = 1; i < DEPTH; i++)
            vld_q[i] <= vld_q[i-1];
      end
   end

   always_ff @(posedge clk_i)
   begin
      data_q[0] <= data_i;
      for (int i = 1; i < DEPTH; i++)
         data_q[i] <= data_q[i-1];
   end

   assign vld_o  = vld_q[DEPTH-1];
   assign data_o = data_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== src/lane_vrf.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_vrf #(
   parameter int VRF_ROWS = vpu_pkg::VRF_ROWS
)
(
   input  logic                clk_i,
   input  vpu_pkg::row_addr_t  rd_row1_i,
   input  vpu_pkg::row_addr_t  rd_row2_i,
   output vpu_pkg::lane_word_t rd1_o,
   output vpu_pkg::lane_word_t rd2_o,
   input  logic                wr_en_i,
   input  vpu_pkg::row_addr_t  wr_row_i,
   input  vpu_pkg::lane_word_t wr_data_i
);
   import vpu_pkg::*;

   lane_word_t mem [VRF_ROWS];

   // Same-row read and write returns the old word
   always_ff @(posedge clk_i)
   begin
      if (wr_en_i)
         mem[wr_row_i] <= wr_data_i;
      rd1_o <= mem[rd_row1_i];
      rd2_o <= mem[rd_row2_i];
   end

endmodule

`default_nettype wire

// ==== src/operand_regroup.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_regroup #(
   parameter int NUM_LANES = vpu_pkg::NUM_LANES
)
(
   input  vpu_pkg::issue_t     issue_i,
   input  vpu_pkg::lane_word_t vs1_i [NUM_LANES],
   input  vpu_pkg::lane_word_t vs2_i [NUM_LANES],
   output vpu_pkg::lane_word_t op_a_o [NUM_LANES],
   output vpu_pkg::lane_word_t op_b_o [NUM_LANES]
);
   import vpu_pkg::*;

   lane_word_t vec_b [NUM_LANES];
   lane_word_t ext;       // Scalar or immediate at full width
   lane_word_t rep;       // Same, repeated per element

   //////////////////////////////
   // Gather elements into ALU slots

   always_comb
   begin
      int s;
      op_a_o = '{default: '0};
      vec_b  = '{default: '0};
      for (int l = 0; l < NUM_LANES; l++)
      begin
         for (int b = 0; b < 4; b++)
         begin
            s = slot_idx(issue_i.sew, l, b);
            op_a_o[s / 4][(s % 4) * 8 +: 8] = vs1_i[l][b * 8 +: 8];
            vec_b[s / 4][(s % 4) * 8 +: 8]  = vs2_i[l][b * 8 +: 8];
         end
      end
   end

   //////////////////////////////
   // Second operand

   always_comb
   begin
      if (issue_i.op2_sel == OP2_SCALAR)
         ext = issue_i.scalar;
      else
         ext = {{27{issue_i.imm[4]}}, issue_i.imm};   // Sign extend

      case (issue_i.sew)
         E8:      rep = {4{ext[7:0]}};
         E16:     rep = {2{ext[15:0]}};
         default: rep = ext;
      endcase

      for (int w = 0; w < NUM_LANES; w++)
      begin
         if (issue_i.op2_sel == OP2_VEC)
            op_b_o[w] = vec_b[w];
         else
            op_b_o[w] = rep;
      end
   end

endmodule

`default_nettype wire

// ==== src/sew_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module sew_alu #(
   parameter int NUM_LANES = vpu_pkg::NUM_LANES
)
(
   input  logic                clk_i,
   input  logic                rst_i,
   input  vpu_pkg::alu_op_e    op_i,
   input  vpu_pkg::sew_e       sew_i,
   input  vpu_pkg::lane_word_t op_a_i [NUM_LANES],
   input  vpu_pkg::lane_word_t op_b_i [NUM_LANES],
   output vpu_pkg::lane_word_t res_o [NUM_LANES]
);
   import vpu_pkg::*;

   lane_word_t slot_d [NUM_LANES];
   lane_word_t slot_q [NUM_LANES];
   sew_e       sew_q;    // Width of the registered result

   // Narrow elements come in zero extended
   function automatic lane_word_t elem_calc(alu_op_e op, lane_word_t a, lane_word_t b);
      case (op)
         OP_ADD:  elem_calc = a + b;
         OP_SUB:  elem_calc = a - b;
         OP_AND:  elem_calc = a & b;
         OP_OR:   elem_calc = a | b;
         OP_XOR:  elem_calc = a ^ b;
         OP_MINU: elem_calc = (a < b) ? a : b;
         OP_MAXU: elem_calc = (a > b) ? a : b;
         OP_PASS: elem_calc = b;
      endcase
   endfunction

   always_comb
   begin
      lane_word_t t;
      lane_word_t r8;
      lane_word_t r16;
      lane_word_t r32;
      for (int w = 0; w < NUM_LANES; w++)
      begin
         r32 = elem_calc(op_i, op_a_i[w], op_b_i[w]);
         for (int h = 0; h < 2; h++)
         begin
            t = elem_calc(op_i, {16'b0, op_a_i[w][h * 16 +: 16]},
                          {16'b0, op_b_i[w][h * 16 +: 16]});
            r16[h * 16 +: 16] = t[15:0];
         end
         for (int q = 0; q < 4; q++)
         begin
            t = elem_calc(op_i, {24'b0, op_a_i[w][q * 8 +: 8]}, {24'b0, op_b_i[w][q * 8 +: 8]});
            r8[q * 8 +: 8] = t[7:0];
         end
         case (sew_i)
            E8:      slot_d[w] = r8;
            E16:     slot_d[w] = r16;
            default: slot_d[w] = r32;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         sew_q <= E8;
      else
         sew_q <= sew_i;
   end

   always_ff @(posedge clk_i)
   begin
      slot_q <= slot_d;
   end

   //////////////////////////////
   // Scatter back to lane bytes

   always_comb
   begin
      int s;
      for (int l = 0; l < NUM_LANES; l++)
      begin
         for (int b = 0; b < 4; b++)
         begin
            s = slot_idx(sew_q, l, b);
            res_o[l][b * 8 +: 8] = slot_q[s / 4][(s % 4) * 8 +: 8];
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/vrf_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module vrf_arbiter #(
   parameter int NUM_LANES = vpu_pkg::NUM_LANES,
   parameter int NUM_SEQ   = vpu_pkg::NUM_SEQ
)
(
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic [NUM_SEQ-1:0]  req_i,
   output logic [NUM_SEQ-1:0]  gnt_o,
   input  vpu_pkg::row_addr_t  rd_row1_i [NUM_SEQ],
   input  vpu_pkg::row_addr_t  rd_row2_i [NUM_SEQ],
   input  vpu_pkg::issue_t     issue_i [NUM_SEQ],
   output vpu_pkg::row_addr_t  rd_row1_o,
   output vpu_pkg::row_addr_t  rd_row2_o,
   output vpu_pkg::issue_t     issue_o,
   output logic                issue_vld_o,
   input  logic                wb_en_i,
   input  vpu_pkg::row_addr_t  wb_row_i,
   input  vpu_pkg::lane_word_t wb_data_i [NUM_LANES],
   input  logic                load_valid_i,
   input  vpu_pkg::row_addr_t  load_row_i,
   input  vpu_pkg::lane_word_t load_data_i [NUM_LANES],
   output logic                wr_en_o,
   output vpu_pkg::row_addr_t  wr_row_o,
   output vpu_pkg::lane_word_t wr_data_o [NUM_LANES],
   output logic                ready_for_load_o
);
   localparam int SEL_W = (NUM_SEQ > 1) ? $clog2(NUM_SEQ) : 1;

   logic [SEL_W-1:0] last_q;   // Last granted, lowest priority now
   logic [SEL_W-1:0] sel;

   //////////////////////////////
   // Read port

   always_comb
   begin
      int   idx;
      logic found;
      gnt_o = '0;
      sel   = last_q;
      found = 1'b0;
      for (int k = 1; k <= NUM_SEQ; k++)
      begin
         idx = (int'(last_q) + k) % NUM_SEQ;
         if (!found && req_i[idx])
         begin
            found      = 1'b1;
            gnt_o[idx] = 1'b1;
            sel        = SEL_W'(idx);
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         last_q <= SEL_W'(NUM_SEQ - 1);   // Sequencer 0 first
      else if (|req_i)
         last_q <= sel;
   end

   assign rd_row1_o   = rd_row1_i[sel];
   assign rd_row2_o   = rd_row2_i[sel];
   assign issue_o     = issue_i[sel];
   assign issue_vld_o = |req_i;

   //////////////////////////////
   // Write port, write-back wins

   assign wr_en_o          = wb_en_i | load_valid_i;
   assign wr_row_o         = wb_en_i ? wb_row_i : load_row_i;
   assign ready_for_load_o = ~wb_en_i;

   always_comb
   begin
      for (int l = 0; l < NUM_LANES; l++)
         wr_data_o[l] = wb_en_i ? wb_data_i[l] : load_data_i[l];
   end

endmodule

`default_nettype wire

// ==== src/elem_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module elem_sequencer
(
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                start_i,
   output logic                ready_o,
   input  vpu_pkg::alu_op_e    op_i,
   input  vpu_pkg::op2_sel_e   op2_sel_i,
   input  vpu_pkg::sew_e       sew_i,
   input  vpu_pkg::row_addr_t  vs1_row_i,
   input  vpu_pkg::row_addr_t  vs2_row_i,
   input  vpu_pkg::row_addr_t  vd_row_i,
   input  vpu_pkg::row_cnt_t   row_cnt_i,
   input  vpu_pkg::lane_word_t scalar_i,
   input  logic [4:0]          imm_i,
   input  logic                store_i,
   input  logic                gnt_i,
   output logic                req_o,
   output vpu_pkg::row_addr_t  rd_row1_o,
   output vpu_pkg::row_addr_t  rd_row2_o,
   output vpu_pkg::issue_t     issue_o
);
   import vpu_pkg::*;

   row_cnt_t   cnt_q;      // Rows still to issue
   row_addr_t  vs1_q;
   row_addr_t  vs2_q;
   row_addr_t  vd_q;
   alu_op_e    op_q;
   op2_sel_e   op2_sel_q;
   sew_e       sew_q;
   lane_word_t scalar_q;
   logic [4:0] imm_q;
   logic       store_q;
   logic       take;

   assign take = start_i && (cnt_q == '0);

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         cnt_q <= '0;
      else if (take)
         cnt_q <= row_cnt_i;
      else if (gnt_i)
         cnt_q <= cnt_q - 1'b1;
   end

   always_ff @(posedge clk_i)
   begin
      if (take)
      begin
         vs1_q    <= vs1_row_i;
         vs2_q    <= vs2_row_i;
         vd_q     <= vd_row_i;
         sew_q    <= sew_i;
         scalar_q <= scalar_i;
         imm_q    <= imm_i;
         store_q  <= store_i;
         if (store_i)
         begin
            op_q      <= OP_PASS;     // Source row rides on vs2
            op2_sel_q <= OP2_VEC;
         end
         else
         begin
            op_q      <= op_i;
            op2_sel_q <= op2_sel_i;
         end
      end
      else if (gnt_i)
      begin
         vs1_q <= vs1_q + 1'b1;
         vs2_q <= vs2_q + 1'b1;
         vd_q  <= vd_q + 1'b1;
      end
   end

   assign ready_o   = (cnt_q == '0);
   assign req_o     = (cnt_q != '0);
   assign rd_row1_o = vs1_q;
   assign rd_row2_o = vs2_q;

   always_comb
   begin
      issue_o.op      = op_q;
      issue_o.op2_sel = op2_sel_q;
      issue_o.sew     = sew_q;
      issue_o.scalar  = scalar_q;
      issue_o.imm     = imm_q;
      issue_o.vd_row  = vd_q;
      issue_o.store   = store_q;
   end

endmodule

`default_nettype wire

// ==== src/vpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vpu_top #(
   parameter int NUM_LANES = vpu_pkg::NUM_LANES,
   parameter int VRF_ROWS  = vpu_pkg::VRF_ROWS,
   parameter int NUM_SEQ   = vpu_pkg::NUM_SEQ
)
(
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic [NUM_SEQ-1:0]  start_i,
   output logic [NUM_SEQ-1:0]  ready_o,
   input  vpu_pkg::alu_op_e    op_i,
   input  vpu_pkg::op2_sel_e   op2_sel_i,
   input  vpu_pkg::sew_e       sew_i,
   input  vpu_pkg::row_addr_t  vs1_row_i,
   input  vpu_pkg::row_addr_t  vs2_row_i,
   input  vpu_pkg::row_addr_t  vd_row_i,
   input  vpu_pkg::row_cnt_t   row_cnt_i,
   input  vpu_pkg::lane_word_t scalar_i,
   input  logic [4:0]          imm_i,
   input  logic                store_i,
   input  logic                load_valid_i,
   input  vpu_pkg::row_addr_t  load_row_i,
   input  vpu_pkg::lane_word_t load_data_i [NUM_LANES],
   output logic                ready_for_load_o,
   output logic                store_valid_o,
   output vpu_pkg::lane_word_t store_data_o [NUM_LANES]
);
   import vpu_pkg::*;

   logic [NUM_SEQ-1:0] req;
   logic [NUM_SEQ-1:0] gnt;
   row_addr_t          seq_row1 [NUM_SEQ];
   row_addr_t          seq_row2 [NUM_SEQ];
   issue_t             seq_issue [NUM_SEQ];

   row_addr_t  rd_row1;
   row_addr_t  rd_row2;
   issue_t     issue;
   logic       issue_vld;
   issue_t     issue_d1;
   logic       issue_vld_d1;
   wb_t        wb_in;
   wb_t        wb_d2;
   logic       wb_vld;
   logic       wb_en;
   logic       wr_en;
   row_addr_t  wr_row;
   lane_word_t wr_data [NUM_LANES];
   lane_word_t rd1 [NUM_LANES];
   lane_word_t rd2 [NUM_LANES];
   lane_word_t op_a [NUM_LANES];
   lane_word_t op_b [NUM_LANES];
   lane_word_t res [NUM_LANES];

   //////////////////////////////
   // Issue side

   for (genvar i = 0; i < NUM_SEQ; i++)
   begin : g_seq
      elem_sequencer u_seq
      (
         .clk_i     (clk_i),
         .rst_i     (rst_i),
         .start_i   (start_i[i]),
         .ready_o   (ready_o[i]),
         .op_i      (op_i),
         .op2_sel_i (op2_sel_i),
         .sew_i     (sew_i),
         .vs1_row_i (vs1_row_i),
         .vs2_row_i (vs2_row_i),
         .vd_row_i  (vd_row_i),
         .row_cnt_i (row_cnt_i),
         .scalar_i  (scalar_i),
         .imm_i     (imm_i),
         .store_i   (store_i),
         .gnt_i     (gnt[i]),
         .req_o     (req[i]),
         .rd_row1_o (seq_row1[i]),
         .rd_row2_o (seq_row2[i]),
         .issue_o   (seq_issue[i])
      );
   end

   vrf_arbiter #(.NUM_LANES(NUM_LANES), .NUM_SEQ(NUM_SEQ)) u_arbiter
   (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .req_i            (req),
      .gnt_o            (gnt),
      .rd_row1_i        (seq_row1),
      .rd_row2_i        (seq_row2),
      .issue_i          (seq_issue),
      .rd_row1_o        (rd_row1),
      .rd_row2_o        (rd_row2),
      .issue_o          (issue),
      .issue_vld_o      (issue_vld),
      .wb_en_i          (wb_en),
      .wb_row_i         (wb_d2.vd_row),
      .wb_data_i        (res),
      .load_valid_i     (load_valid_i),
      .load_row_i       (load_row_i),
      .load_data_i      (load_data_i),
      .wr_en_o          (wr_en),
      .wr_row_o         (wr_row),
      .wr_data_o        (wr_data),
      .ready_for_load_o (ready_for_load_o)
   );

   for (genvar l = 0; l < NUM_LANES; l++)
   begin : g_lane
      lane_vrf #(.VRF_ROWS(VRF_ROWS)) u_vrf
      (
         .clk_i     (clk_i),
         .rd_row1_i (rd_row1),
         .rd_row2_i (rd_row2),
         .rd1_o     (rd1[l]),
         .rd2_o     (rd2[l]),
         .wr_en_i   (wr_en),
         .wr_row_i  (wr_row),
         .wr_data_i (wr_data[l])
      );
   end

   //////////////////////////////
   // Execute side

   stage_delay #(.payload_t(issue_t), .DEPTH(1)) u_issue_dly
   (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .vld_i  (issue_vld),
      .data_i (issue),
      .vld_o  (issue_vld_d1),
      .data_o (issue_d1)
   );

   operand_regroup #(.NUM_LANES(NUM_LANES)) u_regroup
   (
      .issue_i (issue_d1),
      .vs1_i   (rd1),
      .vs2_i   (rd2),
      .op_a_o  (op_a),
      .op_b_o  (op_b)
   );

   sew_alu #(.NUM_LANES(NUM_LANES)) u_alu
   (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .op_i   (issue_d1.op),
      .sew_i  (issue_d1.sew),
      .op_a_i (op_a),
      .op_b_i (op_b),
      .res_o  (res)
   );

   assign wb_in = '{wr_en: ~issue_d1.store, vd_row: issue_d1.vd_row, store: issue_d1.store};

   stage_delay #(.payload_t(wb_t), .DEPTH(1)) u_wb_dly
   (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .vld_i  (issue_vld_d1),
      .data_i (wb_in),
      .vld_o  (wb_vld),
      .data_o (wb_d2)
   );

   // T+2 result goes to the bank or out as a store
   assign wb_en         = wb_vld & wb_d2.wr_en;
   assign store_valid_o = wb_vld & wb_d2.store;
   assign store_data_o  = res;

endmodule

`default_nettype wire

// ==== sim/tb_vpu_model.svh ====
`ifndef TB_VPU_MODEL_SVH
`define TB_VPU_MODEL_SVH

localparam int          ROW_W     = NUM_LANES * 32;
localparam logic [31:0] LFSR_SEED = 32'ha85683ac;
localparam int          OP_ROWS   = 4;
localparam int          NUM_VV    = 21;   // 7 ops at 3 widths
localparam int          NUM_SEL   = 9;    // 3 operand forms at 3 widths
localparam int          INSTR_OVH = 8;    // Start, drain and settle

// Rough cycle cost of each test, loads at one cycle each
localparam int EXP_CYCLES =
   20
   + 8 + (8 + INSTR_OVH)
   + NUM_VV * (2 * OP_ROWS + 2 * (OP_ROWS + INSTR_OVH))
   + NUM_SEL * (OP_ROWS + 2 * (OP_ROWS + INSTR_OVH))
   + 16 + (2 * OP_ROWS + INSTR_OVH) + (8 + INSTR_OVH)
   + 16 + (8 + INSTR_OVH) + 8 + 8 + 2 * (8 + INSTR_OVH);
localparam int CYCLE_LIMIT = 4 * EXP_CYCLES;

logic [31:0]      lfsr_q = LFSR_SEED;
logic [ROW_W-1:0] mem_img [VRF_ROWS];   // Expected register file rows

// x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] lfsr_take(input int nbits);
   logic [31:0] v;
   logic        fb;
   v = '0;
   for (int i = 0; i < nbits; i++)
   begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
   end
   return v;
endfunction

function automatic logic [ROW_W-1:0] rand_row();
   logic [ROW_W-1:0] r;
   for (int l = 0; l < NUM_LANES; l++)
      r[l * 32 +: 32] = lfsr_take(32);
   return r;
endfunction

// Element of w bytes sits at byte p of lanes g to g+w-1, low byte in lane g
function automatic logic [ROW_W-1:0] ref_row(input alu_op_e op, input sew_e sew,
                                             input op2_sel_e sel,
                                             input logic [ROW_W-1:0] a,
                                             input logic [ROW_W-1:0] b,
                                             input logic [31:0] scalar,
                                             input logic [4:0] imm);
   int               w;
   logic [31:0]      mask;
   logic [31:0]      ext;
   logic [31:0]      ea;
   logic [31:0]      eb;
   logic [31:0]      er;
   logic [ROW_W-1:0] r;
   w    = (sew == E8) ? 1 : (sew == E16) ? 2 : 4;
   mask = (w == 4) ? 32'hffff_ffff : ((32'd1 << (8 * w)) - 32'd1);
   ext  = (sel == OP2_SCALAR) ? scalar : {{27{imm[4]}}, imm};
   r    = '0;
   for (int g = 0; g < NUM_LANES; g += w)
   begin
      for (int p = 0; p < 4; p++)
      begin
         ea = '0;
         eb = '0;
         for (int k = 0; k < w; k++)
         begin
            ea[k * 8 +: 8] = a[(g + k) * 32 + p * 8 +: 8];
            eb[k * 8 +: 8] = b[(g + k) * 32 + p * 8 +: 8];
         end
         if (sel != OP2_VEC)
            eb = ext & mask;   // Truncated to the element
         case (op)
            OP_ADD:  er = ea + eb;
            OP_SUB:  er = ea - eb;
            OP_AND:  er = ea & eb;
            OP_OR:   er = ea | eb;
            OP_XOR:  er = ea ^ eb;
            OP_MINU: er = (ea < eb) ? ea : eb;
            OP_MAXU: er = (ea > eb) ? ea : eb;
            default: er = eb;
         endcase
         er = er & mask;
         for (int k = 0; k < w; k++)
            r[(g + k) * 32 + p * 8 +: 8] = er[k * 8 +: 8];
      end
   end
   return r;
endfunction

`endif

// ==== sim/tb_vpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vpu;
   import vpu_pkg::*;

   `include "tb_vpu_model.svh"

   logic               clk;
   logic               rst;
   logic [NUM_SEQ-1:0] start;
   logic [NUM_SEQ-1:0] ready;
   alu_op_e            op;
   op2_sel_e           op2_sel;
   sew_e               sew;
   row_addr_t          vs1_row;
   row_addr_t          vs2_row;
   row_addr_t          vd_row;
   row_cnt_t           row_cnt;
   lane_word_t         scalar;
   logic [4:0]         imm;
   logic               store;
   logic               load_valid;
   row_addr_t          load_row;
   lane_word_t         load_data [NUM_LANES];
   logic               ready_for_load;
   logic               store_valid;
   lane_word_t         store_data [NUM_LANES];

   string              test_name = "reset";
   logic [ROW_W-1:0]   exp_q [$];      // Rows still due on the store port
   row_addr_t          exp_row_q [$];
   int                 cycles = 0;
   int                 held = 0;       // Falling edges a load waited

   vpu_top #(.NUM_LANES(NUM_LANES), .VRF_ROWS(VRF_ROWS), .NUM_SEQ(NUM_SEQ)) u_vpu_top
   (
      .clk_i            (clk),
      .rst_i            (rst),
      .start_i          (start),
      .ready_o          (ready),
      .op_i             (op),
      .op2_sel_i        (op2_sel),
      .sew_i            (sew),
      .vs1_row_i        (vs1_row),
      .vs2_row_i        (vs2_row),
      .vd_row_i         (vd_row),
      .row_cnt_i        (row_cnt),
      .scalar_i         (scalar),
      .imm_i            (imm),
      .store_i          (store),
      .load_valid_i     (load_valid),
      .load_row_i       (load_row),
      .load_data_i      (load_data),
      .ready_for_load_o (ready_for_load),
      .store_valid_o    (store_valid),
      .store_data_o     (store_data)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////
   // Checking helpers

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Regression failed");
      $fatal(1, "stopped at first failure");
   endtask

   task automatic expect_equal(input string what, input logic [ROW_W-1:0] exp_v,
                               input logic [ROW_W-1:0] act_v);
      assert (act_v === exp_v)
      else
         report_failure($sformatf("error %s %s expected %h actual %h",
                                  test_name, what, exp_v, act_v));
   endtask

   function automatic logic [ROW_W-1:0] pack_row(input lane_word_t d [NUM_LANES]);
      logic [ROW_W-1:0] r;
      for (int l = 0; l < NUM_LANES; l++)
         r[l * 32 +: 32] = d[l];
      return r;
   endfunction

   //////////////////////////////
   // Stimulus, all entered on a falling edge

   task automatic start_instr(input int s, input alu_op_e o, input op2_sel_e sel,
                              input sew_e w, input int src1, input int src2, input int dst,
                              input int rows, input lane_word_t sc, input logic [4:0] im,
                              input logic st);
      assert (ready[s] === 1'b1)
      else
         report_failure($sformatf("sequencer %0d busy at start in %s", s, test_name));
      op       = o;
      op2_sel  = sel;
      sew      = w;
      vs1_row  = row_addr_t'(src1);
      vs2_row  = row_addr_t'(src2);
      vd_row   = row_addr_t'(dst);
      row_cnt  = row_cnt_t'(rows);
      scalar   = sc;
      imm      = im;
      store    = st;
      start[s] = 1'b1;
      for (int i = 0; i < rows; i++)
      begin
         if (st)
         begin
            exp_q.push_back(mem_img[src2 + i]);
            exp_row_q.push_back(row_addr_t'(src2 + i));
         end
         else
            mem_img[dst + i] = ref_row(o, w, sel, mem_img[src1 + i], mem_img[src2 + i], sc, im);
      end
      @(negedge clk);
      start[s] = 1'b0;
      assert (ready[s] === 1'b0)
      else
         report_failure($sformatf("sequencer %0d stayed ready after start in %s", s, test_name));
   endtask

   // Last write lands two cycles after ready rises
   task automatic wait_done();
      while (ready !== {NUM_SEQ{1'b1}})
         @(negedge clk);
      repeat (3) @(negedge clk);
   endtask

   task automatic run_op(input alu_op_e o, input op2_sel_e sel, input sew_e w,
                         input lane_word_t sc, input logic [4:0] im);
      start_instr(0, o, sel, w, 0, 8, 16, OP_ROWS, sc, im, 1'b0);
      wait_done();
   endtask

   task automatic run_store(input int src, input int rows);
      start_instr(1, OP_PASS, OP2_VEC, E32, src, src, src, rows, '0, '0, 1'b1);
      wait_done();
   endtask

   task automatic offer_load(input int row, input logic [ROW_W-1:0] data);
      load_valid = 1'b1;
      load_row   = row_addr_t'(row);
      for (int l = 0; l < NUM_LANES; l++)
         load_data[l] = data[l * 32 +: 32];
      while (!ready_for_load)
      begin
         held++;
         @(negedge clk);
      end
      mem_img[row] = data;   // Taken at the next rising edge
      @(negedge clk);
      load_valid = 1'b0;
   endtask

   task automatic load_random(input int first, input int rows);
      for (int i = 0; i < rows; i++)
         offer_load(first + i, rand_row());
   endtask

   //////////////////////////////
   // Tests

   initial
   begin
      lane_word_t sc;
      logic [4:0] im;
      start      = '0;
      op         = OP_ADD;
      op2_sel    = OP2_VEC;
      sew        = E8;
      vs1_row    = '0;
      vs2_row    = '0;
      vd_row     = '0;
      row_cnt    = '0;
      scalar     = '0;
      imm        = '0;
      store      = 1'b0;
      load_valid = 1'b0;
      load_row   = '0;
      load_data  = '{default: '0};
      rst        = 1'b0;
      repeat (16) @(negedge clk);
      rst = 1'b1;
      @(negedge clk);

      expect_equal("ready_o", ROW_W'({NUM_SEQ{1'b1}}), ROW_W'(ready));
      expect_equal("ready_for_load_o", ROW_W'(1), ROW_W'(ready_for_load));
      expect_equal("store_valid_o", '0, ROW_W'(store_valid));

      test_name = "load_store";
      load_random(0, 8);
      run_store(0, 8);

      test_name = "vector_vector";
      for (int k = 0; k < 7; k++)
      begin
         for (int w = 0; w < 3; w++)
         begin
            load_random(0, OP_ROWS);
            load_random(8, OP_ROWS);
            run_op(alu_op_e'(k), OP2_VEC, sew_e'(w), '0, '0);
            run_store(16, OP_ROWS);
         end
      end

      test_name = "operand_select";
      for (int w = 0; w < 3; w++)
      begin
         for (int f = 0; f < 3; f++)
         begin
            load_random(0, OP_ROWS);
            sc    = lfsr_take(32);
            im    = 5'(lfsr_take(4));
            im[4] = (f == 2);   // Negative immediate
            run_op(alu_op_e'((3 * w + f) % 7), (f == 0) ? OP2_SCALAR : OP2_IMM,
                   sew_e'(w), sc, im);
            run_store(16, OP_ROWS);
         end
      end

      // Fields are shared, second start lands one cycle later
      test_name = "dual_sequencer";
      load_random(0, 8);
      load_random(8, 8);
      start_instr(0, OP_ADD, OP2_VEC, E8, 0, 8, 16, OP_ROWS, '0, '0, 1'b0);
      start_instr(1, OP_SUB, OP2_VEC, E16, 4, 12, 20, OP_ROWS, '0, '0, 1'b0);
      wait_done();
      run_store(16, 8);

      test_name = "load_hold";
      load_random(0, 8);
      load_random(8, 8);
      start_instr(0, OP_MAXU, OP2_VEC, E32, 0, 8, 16, 8, '0, '0, 1'b0);
      repeat (3) @(negedge clk);   // Into the write-back window
      held = 0;
      load_random(24, 8);
      assert (held > 0)
      else
         report_failure("no load had to wait for write-back in load_hold");
      wait_done();
      run_store(16, 8);
      run_store(24, 8);

      test_name = "end";
      repeat (4) @(negedge clk);
      if (exp_q.size() == 0)
      begin
         $display("Regression passed");
         $finish;
      end
      else
      begin
         $display("%0d expected store rows never came out", exp_q.size());
         $display("Regression failed");
         $fatal(1, "missing store rows");
      end
   end

   //////////////////////////////
   // Store port comparison

   always @(negedge clk)
   begin : compare_stores
      logic [ROW_W-1:0] act;
      row_addr_t        row;
      if (rst && store_valid)
      begin
         act = pack_row(store_data);
         assert (exp_q.size() > 0)
         else
            report_failure($sformatf("store strobe with no store pending in %s", test_name));
         row = exp_row_q.pop_front();
         expect_equal($sformatf("row %0d", row), exp_q.pop_front(), act);
      end
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      assert (cycles < CYCLE_LIMIT)
      else
         report_failure($sformatf("run did not finish within %0d cycles, stuck in %s",
                                  CYCLE_LIMIT, test_name));
   end

endmodule

`default_nettype wire

// ==== vpu.f ====
+incdir+sim
src/vpu_pkg.sv
src/stage_delay.sv
src/lane_vrf.sv
src/operand_regroup.sv
src/sew_alu.sv
src/vrf_arbiter.sv
src/elem_sequencer.sv
src/vpu_top.sv
sim/tb_vpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_vpu
FILELIST  ?= vpu.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Exit status follows the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
